// File: verilog.f
+incdir+.
aes_ke_types_pkg.sv
aes_gf_pkg.sv
aes_rcon_gen.sv
aes_rot_word_stage.sv
aes_sub_word_stage.sv
aes_key_mix_stage.sv
aes_key_expand_top.sv
tb_aes_key_expand.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the AES key expansion testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_aes_key_expand -f verilog.f
./obj_dir/Vtb_aes_key_expand > sim.log 2>&1 || true
cat sim.log
if grep -q "Simulation failed" sim.log; then
  echo "Testbench reported a failure"
  exit 1
fi
# A run that stopped early never printed its verdict
grep -q "Simulation passed" sim.log

// File: tb_aes_key_model.svh
/*
 * Reference model of one AES-128 key schedule step
 * The S-Box comes from the field inverse and the affine map, not from a table
 */

`ifndef TB_AES_KEY_MODEL_SVH
`define TB_AES_KEY_MODEL_SVH

// Multiply in GF(2^8) modulo 11B
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  p = '0;
  for (int i = 0; i < 8; i++) begin
    if (b[i]) p ^= a;
    a = {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// Inverse as x^254 (zero maps to zero), then the affine map with 63
function automatic logic [7:0] sub_byte(input logic [7:0] x);
  logic [7:0] inv;
  inv = 8'h01;
  for (int i = 0; i < 254; i++) inv = gf_mul(inv, x);
  return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]}
             ^ {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// Next Rcon; going back means finding the value whose double is the current one
function automatic logic [7:0] next_rcon(input logic [7:0] rcon, input logic inv);
  logic [7:0] res;
  res = gf_mul(rcon, 8'h02);
  if (inv) begin
    for (int r = 1; r < 256; r++) begin
      if (gf_mul(r[7:0], 8'h02) == rcon) res = r[7:0];
    end
  end
  return res;
endfunction

// One step on byte lanes, FIPS byte 0 of word 0 sits in bits 7:0
function automatic logic [127:0] expand_step(input logic [127:0] key, input logic inv,
                                             input logic [7:0] rcon);
  logic [31:0]  src;
  logic [31:0]  t;
  logic [127:0] res;
  // Going back, the older last word is words 3 and 2 combined
  src = inv ? key[127:96] ^ key[95:64] : key[127:96];
  for (int j = 0; j < 4; j++) t[8*j +: 8] = sub_byte(src[8*((j+1)%4) +: 8]);
  t[7:0]    = t[7:0] ^ rcon;
  res[31:0] = t ^ key[31:0];
  for (int i = 1; i < 4; i++) begin
    res[32*i +: 32] = inv ? key[32*(i-1) +: 32] ^ key[32*i +: 32]
                          : res[32*(i-1) +: 32] ^ key[32*i +: 32];
  end
  return res;
endfunction

// FIPS-197 hex order, first byte leftmost, into byte lanes
function automatic logic [127:0] fips_to_lanes(input logic [127:0] fips);
  logic [127:0] lanes;
  for (int n = 0; n < 16; n++) lanes[8*n +: 8] = fips[127-8*n -: 8];
  return lanes;
endfunction

`endif

// File: tb_aes_key_expand.sv
/*
 * Testbench for the AES-128 key expansion pipeline
 * Forward and inverse schedules from a table, free running and with stalls
 */

`timescale 1ns/100ps

module tb_aes_key_expand;

  localparam int NumRows      = 20;
  localparam int ItemTimeout  = 50;
  localparam int DrainTimeout = 200;
  localparam logic [127:0] CipherKey = 128'h2b7e151628aed2a6abf7158809cf4f3c;

  `include "tb_aes_key_model.svh"

  logic clk_i;
  logic rst_ni;
  logic in_valid_i;
  logic in_ready_o;
  logic clear_i;
  logic out_valid_o;
  logic out_ready_i;
  aes_ke_types_pkg::aes_key_t key_i;
  aes_ke_types_pkg::aes_key_t key_o;
  aes_ke_types_pkg::ciph_op_e op_i;

  // Stimulus table, one row per item
  aes_ke_types_pkg::aes_key_t row_key [NumRows];
  aes_ke_types_pkg::ciph_op_e row_op [NumRows];
  logic                       row_clear [NumRows];
  aes_ke_types_pkg::aes_key_t row_exp [NumRows];

  // Items in flight, expected key and accept cycle
  aes_ke_types_pkg::aes_key_t exp_q[$];
  int                         acc_q[$];

  aes_ke_types_pkg::aes_key_t held_key;
  logic        was_stalled = 1'b0;
  logic        stall_en;
  logic        check_latency;
  logic        timed_out;
  logic [31:0] lcg_state;
  int          cycle_cnt = 0;
  int          out_count = 0;
  int          value_errs = 0;
  int          other_errs = 0;

  aes_key_expand_top dut_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .key_i       (key_i),
    .op_i        (op_i),
    .clear_i     (clear_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .key_o       (key_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Sink readiness, low on about a quarter of cycles while stalls are on
  initial begin
    out_ready_i = 1'b1;
    lcg_state   = 32'd67;
    forever begin
      @(posedge clk_i);
      #1;
      if (stall_en) begin
        lcg_state   = lcg_next(lcg_state);
        out_ready_i = (lcg_state[17:16] != 2'b00);
      end else begin
        out_ready_i = 1'b1;
      end
    end
  end

  //////////////////////////////
  // Table
  //////////////////////////////

  // Ten forward steps from the cipher key, then ten back from round key 10
  task automatic build_table();
    logic [127:0] cur;
    logic [7:0]   rcon;
    cur  = fips_to_lanes(CipherKey);
    rcon = 8'h01;
    for (int r = 0; r < NumRows; r++) begin
      if (r == NumRows / 2) rcon = 8'h36;
      row_key[r]   = cur;
      row_op[r]    = (r < NumRows / 2) ? aes_ke_types_pkg::CIPH_FWD
                                       : aes_ke_types_pkg::CIPH_INV;
      row_clear[r] = (r % (NumRows / 2)) == 0;
      row_exp[r]   = expand_step(cur, r >= NumRows / 2, rcon);
      cur          = row_exp[r];
      rcon         = next_rcon(rcon, r >= NumRows / 2);
    end
    // Published round keys 1 and 10, and the walk back to the cipher key
    if (row_exp[0] !== fips_to_lanes(128'ha0fafe1788542cb123a339392a6c7605) ||
        row_exp[NumRows/2-1] !== fips_to_lanes(128'hd014f9a8c9ee2589e13f0cc8b6630ca6) ||
        cur !== fips_to_lanes(CipherKey)) begin
      $display("Fail %0t: reference schedule differs from FIPS-197", $time);
      value_errs++;
    end
  endtask

  //////////////////////////////
  // Input side
  //////////////////////////////

  task automatic send_table();
    int   waited;
    logic accepted;
    for (int r = 0; r < NumRows && !timed_out; r++) begin
      in_valid_i = 1'b1;
      key_i      = row_key[r];
      op_i       = row_op[r];
      clear_i    = row_clear[r];
      waited     = 0;
      accepted   = 1'b0;
      while (!accepted && waited < ItemTimeout) begin
        @(posedge clk_i);
        if (in_ready_o) begin
          accepted = 1'b1;
          exp_q.push_back(row_exp[r]);
          acc_q.push_back(cycle_cnt);
        end else begin
          waited++;
        end
      end
      if (!accepted) begin
        $display("Timeout: item %0d not accepted within %0d cycles", r, ItemTimeout);
        other_errs++;
        timed_out = 1'b1;
      end else if (!stall_en && waited != 0) begin
        $display("in_ready_o dropped for item %0d with the sink always ready", r);
        other_errs++;
      end
      #1;
    end
    in_valid_i = 1'b0;
    clear_i    = 1'b0;
  endtask

  // Ends on a rising edge once every accepted item has come out
  task automatic wait_drain();
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      waited++;
    end while (exp_q.size() != 0 && waited < DrainTimeout);
    if (exp_q.size() != 0) begin
      $display("Timeout: %0d items still in the pipeline", exp_q.size());
      other_errs++;
      timed_out = 1'b1;
    end
  endtask

  //////////////////////////////
  // Output side
  //////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni) begin
      // A stalled result stays put until taken
      if (was_stalled && (!out_valid_o || key_o !== held_key)) begin
        $display("Fail %0t: key_o did not hold under back-pressure", $time);
        value_errs++;
      end
      was_stalled = out_valid_o && !out_ready_i;
      held_key    = key_o;
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("Output handshake at %0t with no item in flight", $time);
          other_errs++;
        end else begin
          if (key_o !== exp_q[0]) begin
            $display("Fail %0t: key_o %h, expected %h", $time, key_o, exp_q[0]);
            value_errs++;
          end
          if (check_latency && cycle_cnt - acc_q[0] != 3) begin
            $display("Fail %0t: latency %0d cycles, expected 3", $time, cycle_cnt - acc_q[0]);
            value_errs++;
          end
          void'(exp_q.pop_front());
          void'(acc_q.pop_front());
          out_count++;
        end
      end
    end
  end

  task automatic report_and_finish();
    $display("Errors: %0d wrong values, %0d other failures", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  initial begin
    in_valid_i    = 1'b0;
    key_i         = '0;
    op_i          = aes_ke_types_pkg::CIPH_FWD;
    clear_i       = 1'b0;
    rst_ni        = 1'b0;
    stall_en      = 1'b0;
    check_latency = 1'b0;
    timed_out     = 1'b0;
    build_table();
    repeat (10) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(posedge clk_i);
    if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
      $display("Fail %0t: after reset out_valid_o %b in_ready_o %b", $time,
               out_valid_o, in_ready_o);
      value_errs++;
    end
    // Pass 0 streams with the sink ready, pass 1 adds random stalls
    for (int pass = 0; pass < 2 && !timed_out; pass++) begin
      stall_en      = (pass == 1);
      check_latency = (pass == 0);
      #1;
      send_table();
      if (!timed_out) wait_drain();
    end
    repeat (5) @(posedge clk_i);
    if (out_count != 2 * NumRows) begin
      $display("Expected %0d output items but saw %0d", 2 * NumRows, out_count);
      other_errs++;
    end
    report_and_finish();
  end

endmodule

// File: aes_key_expand_top.sv
/*
 * AES-128 key expansion pipeline
 * Rcon generator feeding three valid/ready stages, one round key step per item
 */

`timescale 1ns/100ps

module aes_key_expand_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  aes_ke_types_pkg::aes_key_t  key_i,
  input  aes_ke_types_pkg::ciph_op_e  op_i,
  input  logic                        clear_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output aes_ke_types_pkg::aes_key_t  key_o
);

  // Input handshake
  logic                        accept;
  aes_ke_types_pkg::aes_byte_t rcon;

  // Stage 1 to stage 2
  logic                        rot_valid;
  logic                        rot_ready;
  aes_ke_types_pkg::ciph_op_e  rot_op;
  aes_ke_types_pkg::aes_byte_t rot_rcon;
  aes_ke_types_pkg::aes_key_t  rot_key;
  aes_ke_types_pkg::aes_word_t rot_word;

  // Stage 2 to stage 3
  logic                        sub_valid;
  logic                        sub_ready;
  aes_ke_types_pkg::ciph_op_e  sub_op;
  aes_ke_types_pkg::aes_byte_t sub_rcon;
  aes_ke_types_pkg::aes_key_t  sub_key;
  aes_ke_types_pkg::aes_word_t sub_word;

  assign accept = in_valid_i & in_ready_o;

  //////////////////////////////
  // Rcon
  //////////////////////////////

  aes_rcon_gen u_rcon_gen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .accept_i (accept),
    .clear_i  (clear_i),
    .op_i     (op_i),
    .rcon_o   (rcon)
  );

  //////////////////////////////
  // Pipeline
  //////////////////////////////

  aes_rot_word_stage u_rot_word_stage (
    .clk_i   (clk_i),      .rst_ni  (rst_ni),
    .valid_i (in_valid_i), .ready_o (in_ready_o),
    .op_i    (op_i),       .rcon_i  (rcon),     .key_i (key_i),
    .valid_o (rot_valid),  .ready_i (rot_ready),
    .op_o    (rot_op),     .rcon_o  (rot_rcon), .key_o (rot_key), .rot_o (rot_word)
  );

  aes_sub_word_stage u_sub_word_stage (
    .clk_i   (clk_i),     .rst_ni  (rst_ni),
    .valid_i (rot_valid), .ready_o (rot_ready),
    .op_i    (rot_op),    .rcon_i  (rot_rcon), .key_i (rot_key), .rot_i (rot_word),
    .valid_o (sub_valid), .ready_i (sub_ready),
    .op_o    (sub_op),    .rcon_o  (sub_rcon), .key_o (sub_key), .sub_o (sub_word)
  );

  aes_key_mix_stage u_key_mix_stage (
    .clk_i   (clk_i),       .rst_ni  (rst_ni),
    .valid_i (sub_valid),   .ready_o (sub_ready),
    .op_i    (sub_op),      .rcon_i  (sub_rcon), .key_i (sub_key), .sub_i (sub_word),
    .valid_o (out_valid_o), .ready_i (out_ready_i),
    .key_o   (key_o)
  );

endmodule

// File: aes_key_mix_stage.sv
/*
 * Key expansion stage 3
 * Adds Rcon to the substituted word and chains the XORs into the new round key
 */

`timescale 1ns/100ps

`include "aes_ke_defines.svh"

module aes_key_mix_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        valid_i,
  output logic                        ready_o,
  input  aes_ke_types_pkg::ciph_op_e  op_i,
  input  aes_ke_types_pkg::aes_byte_t rcon_i,
  input  aes_ke_types_pkg::aes_key_t  key_i,
  input  aes_ke_types_pkg::aes_word_t sub_i,
  output logic                        valid_o,
  input  logic                        ready_i,
  output aes_ke_types_pkg::aes_key_t  key_o
);

  logic                        valid_q;
  logic                        load;
  aes_ke_types_pkg::aes_word_t irregular;
  aes_ke_types_pkg::aes_key_t  key_d;

  assign ready_o = ~valid_q | ready_i;
  assign load    = valid_i & ready_o;

  // Rcon only touches byte 0
  assign irregular = {sub_i[`AES_KE_WORD_W-1:`AES_KE_BYTE_W],
                      sub_i[`AES_KE_BYTE_W-1:0] ^ rcon_i};

  //////////////////////////////
  // Word chaining
  //////////////////////////////

  always_comb begin
    // Word 0 is the same in both directions
    key_d[0] = irregular ^ key_i[0];
    for (int i = 1; i < `AES_KE_KEY_WORDS; i++) begin
      if (op_i == aes_ke_types_pkg::CIPH_FWD) begin
        // Ripple through the freshly built words
        key_d[i] = key_d[i-1] ^ key_i[i];
      end else begin
        // Neighbouring input words recover the older key
        key_d[i] = key_i[i-1] ^ key_i[i];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Output key register
  always_ff @(posedge clk_i) begin
    if (load) begin
      key_o <= key_d;
    end
  end

  assign valid_o = valid_q;

  // Item offered by stage 2 must hold until this stage takes it
  in_hold_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (valid_i && !ready_o) |=> (valid_i && $stable(key_i) && $stable(sub_i)
                               && $stable(rcon_i) && $stable(op_i)))
    else $error("Stage 2 item changed while stalled");

endmodule

// File: aes_sub_word_stage.sv
/*
 * Key expansion stage 2
 * SubWord, every byte of the rotated word goes through the S-Box
 */

`timescale 1ns/100ps

`include "aes_ke_defines.svh"

module aes_sub_word_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        valid_i,
  output logic                        ready_o,
  input  aes_ke_types_pkg::ciph_op_e  op_i,
  input  aes_ke_types_pkg::aes_byte_t rcon_i,
  input  aes_ke_types_pkg::aes_key_t  key_i,
  input  aes_ke_types_pkg::aes_word_t rot_i,
  output logic                        valid_o,
  input  logic                        ready_i,
  output aes_ke_types_pkg::ciph_op_e  op_o,
  output aes_ke_types_pkg::aes_byte_t rcon_o,
  output aes_ke_types_pkg::aes_key_t  key_o,
  output aes_ke_types_pkg::aes_word_t sub_o
);

  localparam int unsigned NumBytes = `AES_KE_WORD_W / `AES_KE_BYTE_W;

  logic                        valid_q;
  logic                        load;
  aes_ke_types_pkg::aes_word_t sub_word;

  assign ready_o = ~valid_q | ready_i;
  assign load    = valid_i & ready_o;

  // Four table lookups in parallel
  always_comb begin
    for (int i = 0; i < NumBytes; i++) begin
      sub_word[i*`AES_KE_BYTE_W +: `AES_KE_BYTE_W] =
          aes_gf_pkg::aes_sbox_lut(rot_i[i*`AES_KE_BYTE_W +: `AES_KE_BYTE_W]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      op_o   <= op_i;
      rcon_o <= rcon_i;
      key_o  <= key_i;
      sub_o  <= sub_word;
    end
  end

  assign valid_o = valid_q;

endmodule

// File: aes_rot_word_stage.sv
/*
 * Key expansion stage 1
 * Picks the source word for the direction and applies RotWord
 */

`timescale 1ns/100ps

`include "aes_ke_defines.svh"

module aes_rot_word_stage (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        valid_i,
  output logic                        ready_o,
  input  aes_ke_types_pkg::ciph_op_e  op_i,
  input  aes_ke_types_pkg::aes_byte_t rcon_i,
  input  aes_ke_types_pkg::aes_key_t  key_i,
  output logic                        valid_o,
  input  logic                        ready_i,
  output aes_ke_types_pkg::ciph_op_e  op_o,
  output aes_ke_types_pkg::aes_byte_t rcon_o,
  output aes_ke_types_pkg::aes_key_t  key_o,
  output aes_ke_types_pkg::aes_word_t rot_o
);

  localparam int unsigned LastWord = `AES_KE_KEY_WORDS - 1;

  logic                        valid_q;
  logic                        load;
  aes_ke_types_pkg::aes_word_t src_word;

  // Accept when empty or when the held item moves on this cycle
  assign ready_o = ~valid_q | ready_i;
  assign load    = valid_i & ready_o;

  // Inverse rebuilds the previous word 3 from words 3 and 2
  always_comb begin
    unique case (op_i)
      aes_ke_types_pkg::CIPH_FWD: src_word = key_i[LastWord];
      aes_ke_types_pkg::CIPH_INV: src_word = key_i[LastWord] ^ key_i[LastWord-1];
      default:                    src_word = key_i[LastWord];
    endcase
  end

  // Stage valid flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (ready_o) begin
      valid_q <= valid_i;
    end
  end

  // Item payload
  always_ff @(posedge clk_i) begin
    if (load) begin
      op_o   <= op_i;
      rcon_o <= rcon_i;
      key_o  <= key_i;
      rot_o  <= aes_gf_pkg::aes_rot_word(src_word);
    end
  end

  assign valid_o = valid_q;

endmodule

// File: aes_rcon_gen.sv
/*
 * AES-128 round constant generator
 * Hands out the Rcon of the item at the input and steps it per accepted item
 */

`timescale 1ns/100ps

`include "aes_ke_defines.svh"

module aes_rcon_gen (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        accept_i,
  input  logic                        clear_i,
  input  aes_ke_types_pkg::ciph_op_e  op_i,
  output aes_ke_types_pkg::aes_byte_t rcon_o
);

  aes_ke_types_pkg::aes_byte_t rcon_q;
  aes_ke_types_pkg::aes_byte_t rcon_init;
  aes_ke_types_pkg::aes_byte_t rcon_next;

  // Start of schedule depends on direction
  assign rcon_init = (op_i == aes_ke_types_pkg::CIPH_FWD) ? `AES_KE_RCON_FWD_INIT
                                                          : `AES_KE_RCON_INV_INIT;

  // Clear overrides the stored value for this very item
  assign rcon_o = clear_i ? rcon_init : rcon_q;

  // Step from the value just used
  assign rcon_next = (op_i == aes_ke_types_pkg::CIPH_FWD) ? aes_gf_pkg::aes_mul2(rcon_o)
                                                          : aes_gf_pkg::aes_div2(rcon_o);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rcon_q <= '0;
    end else if (accept_i) begin
      rcon_q <= rcon_next;
    end
  end

  //////////////////////////////
  // Assertions
  //////////////////////////////

  // A zero Rcon means the schedule was started without clear
  rcon_nonzero_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i |-> (rcon_o != '0))
    else $error("Accepted item uses a zero Rcon");

endmodule

// File: aes_gf_pkg.sv
/*
 * GF(2^8) helpers for the key schedule
 * S-Box lookup, xtime and its inverse, and the word rotation
 */

`include "aes_ke_defines.svh"

package aes_gf_pkg;

  //////////////////////////////
  // S-Box table
  //////////////////////////////

  // Ascending range so entry 0 sits in the first row, first byte
  localparam aes_ke_types_pkg::aes_byte_t [0:255] SBOX_TABLE = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // Forward S-Box
  function automatic aes_ke_types_pkg::aes_byte_t aes_sbox_lut(
    aes_ke_types_pkg::aes_byte_t in_b
  );
    return SBOX_TABLE[in_b];
  endfunction

  //////////////////////////////
  // Field arithmetic
  //////////////////////////////

  // xtime, reduce by x^8 + x^4 + x^3 + x + 1
  function automatic aes_ke_types_pkg::aes_byte_t aes_mul2(
    aes_ke_types_pkg::aes_byte_t in_b
  );
    return {in_b[6:0], 1'b0} ^ (in_b[7] ? 8'h1b : 8'h00);
  endfunction

  // Undo xtime
  // Odd values had the reduction applied, so strip 1b and restore the top bit
  function automatic aes_ke_types_pkg::aes_byte_t aes_div2(
    aes_ke_types_pkg::aes_byte_t in_b
  );
    return in_b[0] ? {1'b1, in_b[7:1] ^ 7'h0d} : {1'b0, in_b[7:1]};
  endfunction

  // RotWord, b0 b1 b2 b3 becomes b1 b2 b3 b0 with b0 in the low byte
  function automatic aes_ke_types_pkg::aes_word_t aes_rot_word(
    aes_ke_types_pkg::aes_word_t in_w
  );
    return {in_w[`AES_KE_BYTE_W-1:0], in_w[`AES_KE_WORD_W-1:`AES_KE_BYTE_W]};
  endfunction

endpackage

// File: aes_ke_types_pkg.sv
/*
 * AES-128 key expansion types
 * Byte, word and round key vectors plus the direction encoding
 */

`include "aes_ke_defines.svh"

package aes_ke_types_pkg;

  // One state byte
  typedef logic [`AES_KE_BYTE_W-1:0] aes_byte_t;

  // One key word, byte 0 in the low bits
  typedef logic [`AES_KE_WORD_W-1:0] aes_word_t;

  // Full round key, word 0 in the low bits
  typedef aes_word_t [`AES_KE_KEY_WORDS-1:0] aes_key_t;

  //////////////////////////////
  // Direction
  //////////////////////////////

  // Forward steps N to N+1, inverse steps N+1 back to N
  typedef enum logic {
    CIPH_FWD = 1'b0,
    CIPH_INV = 1'b1
  } ciph_op_e;

endpackage

// File: aes_ke_defines.svh
/*
 * AES-128 key expansion constants
 * Widths of the key datapath and the first round constants per direction
 */

`ifndef AES_KE_DEFINES_SVH
`define AES_KE_DEFINES_SVH

// Datapath widths
`define AES_KE_WORD_W     32
`define AES_KE_KEY_WORDS  4
`define AES_KE_BYTE_W     8

//////////////////////////////
// Round constants
//////////////////////////////

// First Rcon of a forward schedule
`define AES_KE_RCON_FWD_INIT 8'h01
// First Rcon of an inverse schedule, taken from round 10 of AES-128
`define AES_KE_RCON_INV_INIT 8'h36

`endif
